// File: source/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Memory depths in 32-bit words
`define IMEM_WORDS 64
`define DMEM_WORDS 64

// First fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

// File: source/cpuPkg.sv
package cpuPkg;

    typedef logic [31:0] wordT;
    typedef logic [4:0] regAddrT;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OP_R      = 7'b0110011,
        OP_I      = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011
    } opcodeT;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4
    } aluOpT;

    // Immediate layout picked by the decoder
    typedef enum logic [1:0] {
        IMM_NONE = 2'd0,
        IMM_I    = 2'd1,
        IMM_S    = 2'd2,
        IMM_B    = 2'd3
    } immFmtT;

endpackage

// File: source/ctrlBus.sv
`timescale 1ns/10ps

interface ctrlBus;
    import cpuPkg::*;

    logic    regWrite;
    logic    aluSrc;  // 1 selects imm as operand B
    logic    memWrite;
    logic    memToReg;
    logic    branch;
    aluOpT   aluOp;
    wordT    imm;
    regAddrT rs1;
    regAddrT rs2;
    regAddrT rd;

    modport dec (
        output regWrite, aluSrc, memWrite, memToReg, branch,
        output aluOp, imm, rs1, rs2, rd
    );

    // Datapath side, everything but the ALU operation
    modport dp (
        input regWrite, aluSrc, memWrite, memToReg, branch,
        input imm, rs1, rs2, rd
    );

    modport ex (input aluOp);

endinterface

// File: source/instMem.sv
`timescale 1ns/10ps
`include "cpu_params.svh"

module instMem (
    input  logic                            CLK,
    input  logic                            RST,
    input  logic                            we,
    input  logic [$clog2(`IMEM_WORDS)-1:0]  wAddr,
    input  cpuPkg::wordT                    wData,
    input  cpuPkg::wordT                    rAddr,  // Byte address from the PC
    output cpuPkg::wordT                    inst
);
    import cpuPkg::*;

    localparam int AW = $clog2(`IMEM_WORDS);

    wordT mem [`IMEM_WORDS];

    // Empty words decode as a no-op
    initial begin
        for (int i = 0; i < `IMEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // Program loading only while the core is held in reset
    always_ff @(posedge CLK) begin
        if (RST && we) begin
            mem[wAddr] <= wData;
        end
    end

    assign inst = mem[rAddr[AW+1:2]];  // Drop byte offset

endmodule

// File: source/regFile.sv
`timescale 1ns/10ps

module regFile (
    input  logic             CLK,
    input  logic             RST,
    input  cpuPkg::regAddrT  rs1,
    input  cpuPkg::regAddrT  rs2,
    input  cpuPkg::regAddrT  rd,
    input  logic             we,
    input  cpuPkg::wordT     wd,
    output cpuPkg::wordT     rd1,
    output cpuPkg::wordT     rd2
);
    import cpuPkg::*;

    wordT regs [32];

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wd;  // x0 never written
        end
    end

    // Asynchronous reads, x0 forced to zero
    assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: source/decoder.sv
`timescale 1ns/10ps

module decoder (
    input  cpuPkg::wordT  inst,
    ctrlBus.dec           ctrl
);
    import cpuPkg::*;

    opcodeT     opcode;
    logic [2:0] funct3;
    immFmtT     immFmt;

    assign opcode = opcodeT'(inst[6:0]);
    assign funct3 = inst[14:12];

    // Register fields sit at fixed positions in every format
    assign ctrl.rs1 = inst[19:15];
    assign ctrl.rs2 = inst[24:20];
    assign ctrl.rd  = inst[11:7];

    // Main control and ALU control
    always_comb begin
        ctrl.regWrite = 1'b0;
        ctrl.aluSrc   = 1'b0;
        ctrl.memWrite = 1'b0;
        ctrl.memToReg = 1'b0;
        ctrl.branch   = 1'b0;
        ctrl.aluOp    = ALU_ADD;
        immFmt        = IMM_NONE;
        case (opcode)
            OP_R: begin
                ctrl.regWrite = 1'b1;
                case (funct3)
                    3'b000:  ctrl.aluOp = inst[30] ? ALU_SUB : ALU_ADD;
                    3'b010:  ctrl.aluOp = ALU_SLT;
                    3'b110:  ctrl.aluOp = ALU_OR;
                    3'b111:  ctrl.aluOp = ALU_AND;
                    default: ctrl.regWrite = 1'b0;  // Other R ops act as no-op
                endcase
            end
            OP_I: begin
                ctrl.regWrite = (funct3 == 3'b000);  // addi only
                ctrl.aluSrc   = 1'b1;
                immFmt        = IMM_I;
            end
            OP_LOAD: begin
                ctrl.regWrite = (funct3 == 3'b010);  // lw only
                ctrl.aluSrc   = 1'b1;
                ctrl.memToReg = 1'b1;
                immFmt        = IMM_I;
            end
            OP_STORE: begin
                ctrl.memWrite = (funct3 == 3'b010);  // sw only
                ctrl.aluSrc   = 1'b1;
                immFmt        = IMM_S;
            end
            OP_BRANCH: begin
                ctrl.branch = (funct3 == 3'b000);  // beq only
                ctrl.aluOp  = ALU_SUB;             // Equality through zero flag
                immFmt      = IMM_B;
            end
            default: ;  // Unsupported opcode, nothing enabled
        endcase
    end

    // Sign-extended immediates
    always_comb begin
        case (immFmt)
            IMM_I:   ctrl.imm = {{20{inst[31]}}, inst[31:20]};
            IMM_S:   ctrl.imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            IMM_B:   ctrl.imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                                 inst[11:8], 1'b0};
            default: ctrl.imm = '0;
        endcase
    end

endmodule

// File: source/alu.sv
`timescale 1ns/10ps

module alu (
    ctrlBus.ex            ctrl,
    input  cpuPkg::wordT  a,
    input  cpuPkg::wordT  b,
    output cpuPkg::wordT  result,
    output logic          zero
);
    import cpuPkg::*;

    logic lessThan;

    // Signed compare for slt
    assign lessThan = $signed(a) < $signed(b);

    always_comb begin
        case (ctrl.aluOp)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_SLT: result = {31'd0, lessThan};
            default: result = '0;
        endcase
    end

    assign zero = (result == '0);  // Used by beq

endmodule

// File: source/dataMem.sv
`timescale 1ns/10ps
`include "cpu_params.svh"

module dataMem (
    input  logic          CLK,
    input  logic          RST,
    input  logic          we,
    input  cpuPkg::wordT  addr,  // Byte address, low two bits ignored
    input  cpuPkg::wordT  wd,
    output cpuPkg::wordT  rdata
);
    import cpuPkg::*;

    localparam int AW = $clog2(`DMEM_WORDS);

    wordT mem [`DMEM_WORDS];

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 0; i < `DMEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[addr[AW+1:2]] <= wd;
        end
    end

    assign rdata = mem[addr[AW+1:2]];

endmodule

// File: source/singleCpu.sv
`timescale 1ns/10ps
`include "cpu_params.svh"

module singleCpu (
    input  logic             CLK,
    input  logic             RST,
    input  logic             progWe,
    input  logic [5:0]       progAddr,
    input  cpuPkg::wordT     progData,
    output cpuPkg::wordT     pc,
    output logic             wbEn,
    output cpuPkg::regAddrT  wbAddr,
    output cpuPkg::wordT     wbData
);
    import cpuPkg::*;

    wordT inst;
    wordT nextPc;
    wordT rs1Data;
    wordT rs2Data;
    wordT aluB;
    wordT aluResult;
    logic aluZero;
    wordT memData;
    logic memWe;

    ctrlBus ctrl ();

    instMem uInstMem (
        .CLK   (CLK),
        .RST   (RST),
        .we    (progWe),
        .wAddr (progAddr),
        .wData (progData),
        .rAddr (pc),
        .inst  (inst)
    );

    decoder uDecoder (
        .inst (inst),
        .ctrl (ctrl.dec)
    );

    regFile uRegFile (
        .CLK (CLK),
        .RST (RST),
        .rs1 (ctrl.rs1),
        .rs2 (ctrl.rs2),
        .rd  (ctrl.rd),
        .we  (wbEn),
        .wd  (wbData),
        .rd1 (rs1Data),
        .rd2 (rs2Data)
    );

    // Operand B is rs2 for R-type and beq, imm otherwise
    assign aluB = ctrl.aluSrc ? ctrl.imm : rs2Data;

    alu uAlu (
        .ctrl   (ctrl.ex),
        .a      (rs1Data),
        .b      (aluB),
        .result (aluResult),
        .zero   (aluZero)
    );

    assign memWe = ctrl.memWrite && !RST;

    dataMem uDataMem (
        .CLK   (CLK),
        .RST   (RST),
        .we    (memWe),
        .addr  (aluResult),
        .wd    (rs2Data),
        .rdata (memData)
    );

    // Writeback, also the observation port
    assign wbData = ctrl.memToReg ? memData : aluResult;
    assign wbAddr = ctrl.rd;
    assign wbEn   = ctrl.regWrite && (ctrl.rd != '0) && !RST;

    // Taken beq jumps relative to the current PC
    assign nextPc = (ctrl.branch && aluZero) ? pc + ctrl.imm : pc + 32'd4;

    always_ff @(posedge CLK) begin
        if (RST) begin
            pc <= `RESET_PC;
        end else begin
            pc <= nextPc;
        end
    end

endmodule

// File: test/clockGen.sv
`timescale 1ns/10ps

module clockGen #(
    parameter real periodNs = 4.0
) (
    output logic CLK
);

    initial begin
        CLK = 1'b0;
        forever begin
            #(periodNs / 2.0) CLK = ~CLK;  // Half period per toggle
        end
    end

endmodule

// File: test/singleCpuTb.sv
`timescale 1ns/10ps

module singleCpuTb;
    import cpuPkg::*;

    localparam int resetCycles = 4;
    localparam int waitLimit   = 20;

    logic       CLK;
    logic       RST;
    logic       progWe;
    logic [5:0] progAddr;
    wordT       progData;
    wordT       pc;
    logic       wbEn;
    regAddrT    wbAddr;
    wordT       wbData;

    // Program words and the expected trace, one entry per executed cycle
    wordT    progWords[$];
    string   rowName[$];
    wordT    rowPc[$];
    logic    rowEn[$];
    regAddrT rowAddr[$];
    wordT    rowData[$];
    int      errors;

    clockGen #(.periodNs(4.0)) uClockGen (.CLK(CLK));

    singleCpu u_dut (
        .CLK      (CLK),
        .RST      (RST),
        .progWe   (progWe),
        .progAddr (progAddr),
        .progData (progData),
        .pc       (pc),
        .wbEn     (wbEn),
        .wbAddr   (wbAddr),
        .wbData   (wbData)
    );

    task automatic addRow(input string name, input wordT expPc, input logic expEn,
                          input regAddrT expAddr, input wordT expData);
        rowName.push_back(name);
        rowPc.push_back(expPc);
        rowEn.push_back(expEn);
        rowAddr.push_back(expAddr);
        rowData.push_back(expData);
    endtask

    task automatic buildTables();
        progWords = '{
            32'h0050_0093,  // addi x1, x0, 5
            32'hFFD0_0113,  // addi x2, x0, -3
            32'h0020_81B3,  // add  x3, x1, x2
            32'h4020_8233,  // sub  x4, x1, x2
            32'h0020_F2B3,  // and  x5, x1, x2
            32'h0020_E333,  // or   x6, x1, x2
            32'h0011_23B3,  // slt  x7, x2, x1
            32'h0010_2423,  // sw   x1, 8(x0)
            32'h0080_2403,  // lw   x8, 8(x0)
            32'h0080_8463,  // beq  x1, x8, +8
            32'h0010_0493,  // addi x9, x0, 1 (skipped)
            32'h0020_8463,  // beq  x1, x2, +8
            32'h0070_0013,  // addi x0, x0, 7
            32'h0010_0533   // add  x10, x0, x1
        };
        addRow("addiPos",     32'd0,  1'b1, 5'd1,  32'd5);
        addRow("addiNeg",     32'd4,  1'b1, 5'd2,  32'hFFFF_FFFD);
        addRow("addRegs",     32'd8,  1'b1, 5'd3,  32'd2);
        addRow("subRegs",     32'd12, 1'b1, 5'd4,  32'd8);
        addRow("andRegs",     32'd16, 1'b1, 5'd5,  32'd5);
        addRow("orRegs",      32'd20, 1'b1, 5'd6,  32'hFFFF_FFFD);
        addRow("sltSigned",   32'd24, 1'b1, 5'd7,  32'd1);   // -3 < 5
        addRow("swWord",      32'd28, 1'b0, 5'd0,  32'd0);
        addRow("lwWord",      32'd32, 1'b1, 5'd8,  32'd5);
        addRow("beqTaken",    32'd36, 1'b0, 5'd0,  32'd0);
        addRow("beqNotTaken", 32'd44, 1'b0, 5'd0,  32'd0);   // Word 40 skipped
        addRow("addiToX0",    32'd48, 1'b0, 5'd0,  32'd0);
        addRow("addFromX0",   32'd52, 1'b1, 5'd10, 32'd5);
        addRow("emptyNop",    32'd56, 1'b0, 5'd0,  32'd0);
        addRow("afterNop",    32'd60, 1'b0, 5'd0,  32'd0);
    endtask

    task automatic checkValue(input string name, input string field,
                              input wordT expected, input wordT actual);
        if (actual !== expected) begin
            $display("ERROR %s %s expected %h actual %h", name, field, expected, actual);
            errors++;
        end
    endtask

    // PC parked at zero and no writeback while held in reset
    task automatic checkResetState();
        checkValue("reset", "pc", 32'd0, pc);
        checkValue("reset", "wbEn", 32'd0, wbEn);
    endtask

    // Loader keeps RST high, so the reset stretches over the whole program
    task automatic loadProgram();
        for (int i = 0; i < progWords.size(); i++) begin
            @(posedge CLK);
            progWe   <= 1'b1;
            progAddr <= i[5:0];
            progData <= progWords[i];
            @(negedge CLK);
            checkResetState();  // Loaded words must not execute yet
        end
        @(posedge CLK);
        progWe <= 1'b0;
        RST    <= 1'b0;  // Last word still lands on this edge
    endtask

    initial begin
        int waited;
        errors   = 0;
        waited   = 0;
        RST      = 1'b1;
        progWe   = 1'b0;
        progAddr = '0;
        progData = '0;
        buildTables();

        @(posedge CLK);  // First edge loads the reset PC
        for (int i = 0; i < resetCycles; i++) begin
            @(negedge CLK);
            checkResetState();
        end
        loadProgram();

        // First instruction writes x1
        @(negedge CLK);
        while (wbEn !== 1'b1 && waited < waitLimit) begin
            @(negedge CLK);
            waited++;
        end

        if (wbEn !== 1'b1) begin
            $display("No writeback seen within %0d cycles after reset", waitLimit);
            errors++;
        end else begin
            for (int i = 0; i < rowName.size(); i++) begin
                if (i > 0) begin
                    @(negedge CLK);
                end
                checkValue(rowName[i], "pc", rowPc[i], pc);
                checkValue(rowName[i], "wbEn", rowEn[i], wbEn);
                if (rowEn[i]) begin
                    checkValue(rowName[i], "wbAddr", rowAddr[i], wbAddr);
                    checkValue(rowName[i], "wbData", rowData[i], wbData);
                end
            end
        end

        $display("Checked %0d rows, %0d errors", rowName.size(), errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+source
source/cpuPkg.sv
source/ctrlBus.sv
source/instMem.sv
source/regFile.sv
source/decoder.sv
source/alu.sv
source/dataMem.sv
source/singleCpu.sv
test/clockGen.sv
test/singleCpuTb.sv
